/* src/psrDefs.sv */
`default_nettype none

package psrDefs;

  // Status word and its fields
  typedef logic [31:0] psr_t;     // Full CPSR/SPSR word
  typedef logic [4:0]  mode_t;    // M[4:0] field
  typedef logic [3:0]  flags_t;   // N Z C V
  typedef logic [3:0]  byteEn_t;  // One bit per byte, control at bit 0
  typedef logic [2:0]  slot_t;    // SPSR bank index

  // Mode encodings, ARM architectural values
  localparam mode_t modeUsr = 5'b10000;
  localparam mode_t modeFiq = 5'b10001;
  localparam mode_t modeIrq = 5'b10010;
  localparam mode_t modeSvc = 5'b10011;
  localparam mode_t modeAbt = 5'b10111;
  localparam mode_t modeUnd = 5'b11011;
  localparam mode_t modeSys = 5'b11111;

  // SPSR bank slots
  localparam slot_t slotSvc = 3'd0;
  localparam slot_t slotAbt = 3'd1;  // Shared by both aborts
  localparam slot_t slotUnd = 3'd2;
  localparam slot_t slotIrq = 3'd3;
  localparam slot_t slotFiq = 3'd4;
  localparam int spsrCount = 5;

  // Bit positions in the status word
  localparam int modeMsb    = 4;   // Mode occupies [modeMsb:0]
  localparam int fiqMaskBit = 6;   // F
  localparam int irqMaskBit = 7;   // I
  localparam int flagsLsb   = 28;  // NZCV at [31:28]

  // Reset value
  // Supervisor, I and F set, Thumb bit and flags clear
  localparam psr_t cpsrResetValue = {24'h0, 1'b1, 1'b1, 1'b0, modeSvc};

endpackage

`default_nettype wire

/* src/exceptionDefs.sv */
`default_nettype none

package exceptionDefs;

  // Raw exception request lines, one level per source
  typedef struct packed {
    logic undef;
    logic swi;
    logic prefetchAbort;
    logic dataAbort;
    logic irq;
    logic fiq;
  } excReq_t;

  // One-hot vector select, bit i picks vector table entry i
  typedef logic [6:0] vectorSel_t;

  localparam vectorSel_t vecReset     = 7'b000_0001;
  localparam vectorSel_t vecUndef     = 7'b000_0010;
  localparam vectorSel_t vecSwi       = 7'b000_0100;
  localparam vectorSel_t vecPrefetch  = 7'b000_1000;
  localparam vectorSel_t vecDataAbort = 7'b001_0000;
  localparam vectorSel_t vecIrq       = 7'b010_0000;
  localparam vectorSel_t vecFiq       = 7'b100_0000;

  // What the CPSR and SPSR bank need to know about a taken exception
  typedef struct packed {
    logic           taken;       // Entry happens this cycle
    psrDefs::mode_t newMode;     // Mode to switch into
    logic           setFiqMask;  // FIQ entry also masks FIQ
    psrDefs::slot_t slot;        // SPSR receiving the old CPSR
  } excEntry_t;

endpackage

`default_nettype wire

/* src/exceptionPriority.sv */
`timescale 1ns/1ps
`default_nettype none

module exceptionPriority (
  input  logic                      reset,
  input  exceptionDefs::excReq_t    excReq,
  input  psrDefs::mode_t            mode,
  output exceptionDefs::excEntry_t  entry,
  output exceptionDefs::vectorSel_t vectorSel
);
  import psrDefs::*;
  import exceptionDefs::*;

  excReq_t    eligible;   // Requests not already served by the current mode
  vectorSel_t excVector;  // Vector of the winning request

  function automatic excEntry_t makeEntry(input mode_t newMode, input logic setFiq,
                                          input slot_t slot);
    excEntry_t e;
    e.taken      = 1'b1;
    e.newMode    = newMode;
    e.setFiqMask = setFiq;
    e.slot       = slot;
    return e;
  endfunction

  // Drop any request whose target mode is where we already are
  always_comb begin
    eligible.undef         = excReq.undef         & (mode != modeUnd);
    eligible.swi           = excReq.swi           & (mode != modeSvc);
    eligible.prefetchAbort = excReq.prefetchAbort & (mode != modeAbt);
    eligible.dataAbort     = excReq.dataAbort     & (mode != modeAbt);
    eligible.irq           = excReq.irq           & (mode != modeIrq);
    eligible.fiq           = excReq.fiq           & (mode != modeFiq);
  end

  // Fixed priority: dabt, fiq, irq, pabt, undef, swi
  always_comb begin
    entry     = '0;  // Nothing taken
    excVector = '0;
    if (eligible.dataAbort) begin
      entry     = makeEntry(modeAbt, 1'b0, slotAbt);
      excVector = vecDataAbort;
    end else if (eligible.fiq) begin
      entry     = makeEntry(modeFiq, 1'b1, slotFiq);  // Only FIQ masks F
      excVector = vecFiq;
    end else if (eligible.irq) begin
      entry     = makeEntry(modeIrq, 1'b0, slotIrq);
      excVector = vecIrq;
    end else if (eligible.prefetchAbort) begin
      entry     = makeEntry(modeAbt, 1'b0, slotAbt);
      excVector = vecPrefetch;
    end else if (eligible.undef) begin
      entry     = makeEntry(modeUnd, 1'b0, slotUnd);
      excVector = vecUndef;
    end else if (eligible.swi) begin
      entry     = makeEntry(modeSvc, 1'b0, slotSvc);
      excVector = vecSwi;
    end
  end

  // Reset vector wins while reset is held
  assign vectorSel = reset ? vecReset : excVector;

endmodule

`default_nettype wire

/* src/psrAccessDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module psrAccessDecode (
  input  psrDefs::mode_t   mode,
  input  logic [4:0]       msrMask,     // [4] SPSR target, [3:0] field mask
  output psrDefs::slot_t   spsrSlot,
  output logic             spsrValid,
  output psrDefs::byteEn_t cpsrByteEn,
  output psrDefs::byteEn_t spsrByteEn,
  output logic             msrActive
);
  import psrDefs::*;

  byteEn_t fieldMask;   // f s x c
  logic    spsrTarget;  // R bit of MSR
  logic    privileged;  // Anything but user

  assign fieldMask  = msrMask[3:0];
  assign spsrTarget = msrMask[4];
  assign privileged = (mode != modeUsr);

  // Bank slot of the current mode
  always_comb begin
    spsrSlot  = slotSvc;
    spsrValid = 1'b1;
    case (mode)
      modeSvc: spsrSlot = slotSvc;
      modeAbt: spsrSlot = slotAbt;
      modeUnd: spsrSlot = slotUnd;
      modeIrq: spsrSlot = slotIrq;
      modeFiq: spsrSlot = slotFiq;
      modeUsr: spsrValid = 1'b0;  // No SPSR in user
      modeSys: spsrValid = 1'b0;  // Nor in system
      default: spsrValid = 1'b0;  // Reserved encodings
    endcase
  end

  // Flags byte is open to user mode, the rest is privileged only
  assign cpsrByteEn = spsrTarget ? '0 :
                      {fieldMask[3], fieldMask[2:0] & {3{privileged}}};

  // SPSR write needs a mode that owns one
  assign spsrByteEn = (spsrTarget && spsrValid) ? fieldMask : '0;

  // Any MSR at all, even one that ends up writing nothing
  assign msrActive = |fieldMask;

endmodule

`default_nettype wire

/* src/spsrBank.sv */
`timescale 1ns/1ps
`default_nettype none

module spsrBank (
  input  logic                     clk,
  input  logic                     reset,
  input  exceptionDefs::excEntry_t entry,
  input  psrDefs::psr_t            cpsr,
  input  psrDefs::psr_t            msrData,
  input  psrDefs::byteEn_t         spsrByteEn,
  input  psrDefs::slot_t           spsrSlot,
  input  logic                     spsrValid,
  output psrDefs::psr_t            spsrData
);
  import psrDefs::*;

  psr_t spsrRegs [spsrCount];  // svc abt und irq fiq

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      for (int i = 0; i < spsrCount; i++) begin
        spsrRegs[i] <= '0;
      end
    end else if (entry.taken) begin
      spsrRegs[entry.slot] <= cpsr;  // Save pre-exception CPSR
    end else begin
      // MSR SPSR, every enabled byte together
      for (int b = 0; b < $bits(byteEn_t); b++) begin
        if (spsrByteEn[b]) begin
          spsrRegs[spsrSlot][8*b +: 8] <= msrData[8*b +: 8];
        end
      end
    end
  end

  // User and system have no SPSR, show the CPSR instead
  assign spsrData = spsrValid ? spsrRegs[spsrSlot] : cpsr;

endmodule

`default_nettype wire

/* src/cpsrReg.sv */
`timescale 1ns/1ps
`default_nettype none

module cpsrReg (
  input  logic                     clk,
  input  logic                     reset,
  input  exceptionDefs::excEntry_t entry,
  input  psrDefs::psr_t            msrData,
  input  psrDefs::byteEn_t         cpsrByteEn,
  input  logic                     msrActive,
  input  psrDefs::flags_t          flagsNext,
  input  logic                     notStall,
  output psrDefs::psr_t            cpsr
);
  import psrDefs::*;

  psr_t cpsrNext;

  // Entry beats MSR, MSR beats the flag load
  always_comb begin
    cpsrNext = cpsr;  // Hold by default
    if (entry.taken) begin
      cpsrNext[modeMsb:0]  = entry.newMode;
      cpsrNext[irqMaskBit] = 1'b1;  // Always mask IRQ on entry
      if (entry.setFiqMask) begin
        cpsrNext[fiqMaskBit] = 1'b1;
      end
    end else if (msrActive) begin
      // Privilege already folded into the enables
      for (int b = 0; b < $bits(byteEn_t); b++) begin
        if (cpsrByteEn[b]) begin
          cpsrNext[8*b +: 8] = msrData[8*b +: 8];
        end
      end
    end else if (notStall) begin
      cpsrNext[flagsLsb +: $bits(flags_t)] = flagsNext;  // NZCV from ALU
    end
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      cpsr <= cpsrResetValue;  // svc, I and F set
    end else begin
      cpsr <= cpsrNext;
    end
  end

endmodule

`default_nettype wire

/* src/statusUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module statusUnit (
  input  logic                      clk,
  input  logic                      reset,
  input  exceptionDefs::excReq_t    excReq,
  input  logic [4:0]                msrMask,
  input  psrDefs::psr_t             msrData,
  input  psrDefs::flags_t           flagsNext,
  input  logic                      notStall,
  output psrDefs::psr_t             cpsrData,
  output psrDefs::psr_t             spsrData,
  output exceptionDefs::vectorSel_t vectorSel
);
  import psrDefs::*;
  import exceptionDefs::*;

  mode_t     mode;        // Current mode, straight from the CPSR
  excEntry_t entry;
  slot_t     spsrSlot;
  logic      spsrValid;
  byteEn_t   cpsrByteEn;
  byteEn_t   spsrByteEn;
  logic      msrActive;

  assign mode = cpsrData[modeMsb:0];

  exceptionPriority priority_i (
    .reset, .excReq, .mode, .entry, .vectorSel
  );

  psrAccessDecode decode_i (
    .mode, .msrMask, .spsrSlot, .spsrValid, .cpsrByteEn, .spsrByteEn, .msrActive
  );

  spsrBank spsrBank_i (
    .clk, .reset, .entry, .cpsr(cpsrData), .msrData, .spsrByteEn,
    .spsrSlot, .spsrValid, .spsrData
  );

  cpsrReg cpsrReg_i (
    .clk, .reset, .entry, .msrData, .cpsrByteEn, .msrActive,
    .flagsNext, .notStall, .cpsr(cpsrData)
  );

endmodule

`default_nettype wire

/* sim/statusUnit_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module statusUnitAssertions (
  input logic                      clk,
  input logic                      reset,
  input psrDefs::mode_t            mode,
  input exceptionDefs::excEntry_t  entry,
  input logic                      msrActive,
  input logic                      notStall,
  input psrDefs::psr_t             cpsrData,
  input exceptionDefs::vectorSel_t vectorSel
);
  import psrDefs::*;
  import exceptionDefs::*;

  int failCount = 0;  // Summed into the testbench result

  // At most one vector once out of reset, and one only with a taken entry
  vectorOneHot: assert property (@(posedge clk) disable iff (reset)
      $onehot0(vectorSel) && ((vectorSel != '0) == entry.taken))
    else begin
      $error("vectorSel %b does not match entry taken %b", vectorSel, entry.taken);
      failCount++;
    end

  // Mode follows the entry record one edge later
  entryMode: assert property (@(posedge clk) disable iff (reset)
      entry.taken |=> cpsrData[modeMsb:0] == $past(entry.newMode))
    else begin
      $error("Mode after exception entry is %b", cpsrData[modeMsb:0]);
      failCount++;
    end

  // User MSR only reaches the flags byte
  userMsrLocked: assert property (@(posedge clk) disable iff (reset)
      (mode == modeUsr && msrActive && !entry.taken) |=> cpsrData[23:0] == $past(cpsrData[23:0]))
    else begin
      $error("User mode MSR changed a privileged CPSR byte");
      failCount++;
    end

  // Stalled writeback, nothing else going on
  flagsHeld: assert property (@(posedge clk) disable iff (reset)
      (!notStall && !entry.taken && !msrActive) |=> cpsrData[31:28] == $past(cpsrData[31:28]))
    else begin
      $error("Flags changed while writeback was stalled");
      failCount++;
    end

endmodule

`default_nettype wire

/* sim/statusUnitTb.sv */
`timescale 1ns/1ps
`default_nettype none

module statusUnitTb;
  import psrDefs::*;
  import exceptionDefs::*;

  localparam int maxCycles = 400;  // Tests below take roughly 270

  // Single request patterns, bit order of excReq_t
  localparam excReq_t reqNone  = 6'b000000;
  localparam excReq_t reqUndef = 6'b100000;
  localparam excReq_t reqSwi   = 6'b010000;
  localparam excReq_t reqPabt  = 6'b001000;
  localparam excReq_t reqDabt  = 6'b000100;
  localparam excReq_t reqIrq   = 6'b000010;
  localparam excReq_t reqFiq   = 6'b000001;

  // Priority list, index 0 wins
  localparam mode_t targetOf [6] = '{modeAbt, modeFiq, modeIrq, modeAbt, modeUnd, modeSvc};
  localparam vectorSel_t vecOf [6] = '{vecDataAbort, vecFiq, vecIrq,
                                       vecPrefetch, vecUndef, vecSwi};
  localparam mode_t modeTable [7] = '{modeUsr, modeFiq, modeIrq, modeSvc,
                                      modeAbt, modeUnd, modeSys};

  logic       clk = 1'b0;
  logic       reset;
  excReq_t    excReq;
  logic [4:0] msrMask;
  psr_t       msrData;
  flags_t     flagsNext;
  logic       notStall;
  psr_t       cpsrData;
  psr_t       spsrData;
  vectorSel_t vectorSel;

  psr_t        refCpsr = 32'h0000_00d3;  // svc, I and F set
  psr_t        refSpsr [5] = '{default: '0};
  logic [31:0] lfsr;
  int          errors = 0;
  int          cycles = 0;

  statusUnit dut_i (
    .clk, .reset, .excReq, .msrMask, .msrData, .flagsNext, .notStall,
    .cpsrData, .spsrData, .vectorSel
  );

  bind statusUnit statusUnitAssertions assertions_i (
    .clk(clk), .reset(reset), .mode(mode), .entry(entry), .msrActive(msrActive),
    .notStall(notStall), .cpsrData(cpsrData), .vectorSel(vectorSel)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= maxCycles) begin
      $display("Timeout: tests still running after %0d cycles", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  // Random word with a legal mode field
  function automatic psr_t randPsr();
    psr_t v;
    v = randBits(32);
    v[4:0] = modeTable[3'(randBits(3) % 7)];
    return v;
  endfunction

  // Bank index, -1 for usr, sys and reserved modes
  function automatic int bankOf(input mode_t m);
    case (m)
      modeSvc: return 0;
      modeAbt: return 1;
      modeUnd: return 2;
      modeIrq: return 3;
      modeFiq: return 4;
      default: return -1;
    endcase
  endfunction

  task automatic compare(input string name, input string what,
                         input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("FAILED %s %s: expected %h, actual %h", name, what, exp, act);
      errors++;
    end
  endtask

  // Reference model, check this cycle then step to the next state
  task automatic checkAndAdvance(input string name);
    logic [0:5] pending;
    mode_t      cur;
    mode_t      tgt;
    vectorSel_t expVec;
    int         slot;
    if (reset) begin
      compare(name, "cpsrData", 32'h0000_00d3, cpsrData);
      compare(name, "spsrData", 32'h0, spsrData);
      compare(name, "vectorSel", 32'(vecReset), 32'(vectorSel));
      return;
    end
    pending = {excReq.dataAbort, excReq.fiq, excReq.irq,
               excReq.prefetchAbort, excReq.undef, excReq.swi};
    cur    = refCpsr[4:0];
    tgt    = cur;
    expVec = '0;
    for (int i = 0; i < 6; i++) begin
      if (pending[i] && targetOf[i] != cur && expVec == '0) begin
        expVec = vecOf[i];  // First eligible one
        tgt    = targetOf[i];
      end
    end
    slot = bankOf(cur);
    compare(name, "cpsrData", refCpsr, cpsrData);
    compare(name, "spsrData", (slot < 0) ? refCpsr : refSpsr[slot], spsrData);
    compare(name, "vectorSel", 32'(expVec), 32'(vectorSel));
    if (expVec != '0) begin
      refSpsr[bankOf(tgt)] = refCpsr;  // Old CPSR saved
      refCpsr[4:0] = tgt;
      refCpsr[7]   = 1'b1;
      if (expVec == vecFiq) begin
        refCpsr[6] = 1'b1;
      end
    end else if (msrMask[3:0] != '0) begin
      for (int b = 0; b < 4; b++) begin
        if (msrMask[b] && msrMask[4] && slot >= 0) begin
          refSpsr[slot][8*b +: 8] = msrData[8*b +: 8];
        end
        if (msrMask[b] && !msrMask[4] && (b == 3 || cur != modeUsr)) begin
          refCpsr[8*b +: 8] = msrData[8*b +: 8];  // Flags byte open to user
        end
      end
    end else if (notStall) begin
      refCpsr[31:28] = flagsNext;
    end
  endtask

  // Entered on a falling edge, leaves on the next one
  task automatic applyCycle(input string name, input excReq_t req, input logic [4:0] mask,
                            input psr_t data, input flags_t flags, input logic ns);
    excReq    = req;
    msrMask   = mask;
    msrData   = data;
    flagsNext = flags;
    notStall  = ns;
    #40;  // Settled, just ahead of the rising edge
    checkAndAdvance(name);
    @(negedge clk);
  endtask

  initial begin
    excReq_t    req;
    logic [4:0] mask;
    int         assertFails;
    reset     = 1'b1;
    excReq    = '0;
    msrMask   = '0;
    msrData   = '0;
    flagsNext = '0;
    notStall  = 1'b0;
    lfsr      = 32'hcca7;
    @(negedge clk);
    repeat (3) applyCycle("reset", reqNone, 5'b0, '0, '0, 1'b0);
    reset = 1'b0;  // Four rising edges in reset

    // Flag load, sometimes blocked by an SPSR-only MSR
    repeat (40) begin
      mask = (randBits(3) == 0) ? 5'b10001 : 5'b00000;
      applyCycle("flags", reqNone, mask, randPsr(), 4'(randBits(4)), 1'(randBits(1)));
    end

    // Each request alone, then again in its own mode
    applyCycle("entry", reqUndef, 5'b0, '0, '0, 1'b0);
    applyCycle("entry", reqUndef, 5'b0, '0, '0, 1'b0);
    applyCycle("entry", reqFiq, 5'b0, '0, '0, 1'b0);
    applyCycle("entry", reqFiq, 5'b0, '0, '0, 1'b0);
    applyCycle("entry", reqIrq, 5'b0, '0, '0, 1'b0);
    applyCycle("entry", reqDabt, 5'b0, '0, '0, 1'b0);
    applyCycle("entry", reqPabt, 5'b0, '0, '0, 1'b0);
    applyCycle("entry", reqSwi, 5'b0, '0, '0, 1'b0);
    applyCycle("entry", reqSwi, 5'b0, '0, '0, 1'b0);
    applyCycle("entry", reqPabt, 5'b0, '0, '0, 1'b0);
    applyCycle("entry", reqIrq, 5'b0, '0, '0, 1'b0);
    applyCycle("entry", reqNone, 5'b0, '0, '0, 1'b0);

    // MSR to CPSR, drop to user then try every byte
    applyCycle("msrCpsr", reqNone, 5'b01111, {24'(randBits(24)), 8'h10}, '0, 1'b1);
    applyCycle("msrCpsr", reqNone, 5'b01111, randPsr(), '0, 1'b1);
    applyCycle("msrSpsr", reqNone, 5'b11111, randPsr(), '0, 1'b1);  // No SPSR in user
    applyCycle("entry", reqIrq, 5'b0, '0, '0, 1'b0);

    // MSR to SPSR in irq, then in system mode
    applyCycle("msrSpsr", reqNone, 5'b11111, randPsr(), '0, 1'b0);
    applyCycle("msrSpsr", reqNone, 5'b10100, randPsr(), '0, 1'b0);
    applyCycle("msrCpsr", reqNone, 5'b00001, {24'h0, 8'h1f}, '0, 1'b0);
    applyCycle("msrSpsr", reqNone, 5'b11111, randPsr(), '0, 1'b0);
    applyCycle("msrCpsr", reqNone, 5'b00001, {24'h0, 8'h10}, '0, 1'b0);

    // Random request mixes with the odd MSR
    repeat (200) begin
      req  = excReq_t'(6'(randBits(6)));
      mask = (randBits(3) == 0) ? 5'(randBits(5)) : 5'b00000;
      applyCycle("random", req, mask, randPsr(), 4'(randBits(4)), 1'(randBits(1)));
    end

    assertFails = dut_i.assertions_i.failCount;
    $display("Errors: %0d compare, %0d assertion", errors, assertFails);
    if (errors == 0 && assertFails == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
src/psrDefs.sv
src/exceptionDefs.sv
src/exceptionPriority.sv
src/psrAccessDecode.sv
src/spsrBank.sv
src/cpsrReg.sv
src/statusUnit.sv
sim/statusUnit_assertions.sv
sim/statusUnitTb.sv
